// ==== Makefile ====
TOP = rename_stage_tb
LOG = sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "No errors" $(LOG)

obj_dir/V$(TOP): rename_stage.f verilog/*.sv testbench/rename_stage_tb.sv include/rename_checks.svh
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f rename_stage.f

lint:
	verilator --lint-only --timing -Wall --top-module rename_stage -f rename_stage.f

clean:
	rm -rf obj_dir $(LOG)

// ==== rename_stage.f ====
+incdir+include
verilog/rename_arch_pkg.sv
verilog/rename_bus_pkg.sv
verilog/rename_interfaces.sv
verilog/free_reg_stack.sv
verilog/register_file.sv
verilog/rename_stage.sv
testbench/rename_stage_tb.sv

// ==== include/rename_checks.svh ====
// Rename stage compare tasks
`ifndef RENAME_CHECKS_SVH
`define RENAME_CHECKS_SVH

int error_count = 0;
int check_count = 0;

task automatic report_fail(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  error_count++;
  $display("Fail %0t %s expected %0h actual %0h", $time, name, expected, actual);
endtask

task automatic check_num(input string name, input rename_arch_pkg::reg_num_t expected,
                         input rename_arch_pkg::reg_num_t actual);
  check_count++;
  if (actual !== expected) begin
    report_fail(name, 32'(expected), 32'(actual));
  end
endtask

task automatic check_value(input string name, input rename_arch_pkg::reg_value_t expected,
                           input rename_arch_pkg::reg_value_t actual);
  check_count++;
  if (actual !== expected) begin
    report_fail(name, expected, actual);
  end
endtask

task automatic check_ready(input string name, input logic expected, input logic actual);
  check_count++;
  if (actual !== expected) begin
    report_fail(name, 32'(expected), 32'(actual));
  end
endtask

task automatic check_capacity(input string name, input rename_arch_pkg::capacity_t expected,
                              input rename_arch_pkg::capacity_t actual);
  check_count++;
  if (actual !== expected) begin
    report_fail(name, 32'(expected), 32'(actual));
  end
endtask

`endif

// ==== testbench/rename_stage_tb.sv ====
// Rename stage testbench
`timescale 1ns/1ps

module rename_stage_tb
  import rename_arch_pkg::*;
  import rename_bus_pkg::*;
();

  `include "rename_checks.svh"

  logic       clock;
  logic       reset;
  logic       rename [rename_width];
  logic       tag [rename_width];
  arch_num_t  rd [rename_width];
  arch_num_t  rs1 [rename_width];
  arch_num_t  rs2 [rename_width];
  reg_num_t   rn [rename_width];
  reg_num_t   rs1_ren [rename_width];
  reg_num_t   rs2_ren [rename_width];
  reg_num_t   src [read_ports];
  reg_value_t src_value [read_ports];
  logic       src_ready [read_ports];
  logic       cdb_write [cdb_ports];
  reg_num_t   cdb_arn [cdb_ports];
  reg_num_t   cdb_rrn [cdb_ports];
  reg_value_t cdb_result [cdb_ports];
  logic       delete_tag;
  logic       clear_tag;
  capacity_t  capacity;

  // One entry per test line, fields a to e then capacity
  string            op_q [$];
  logic [5:0][31:0] arg_q [$];
  int               line_count = 0;
  bit               tests_loaded = 1'b0;

  rename_stage UUT (
    .i_clock      (clock),
    .i_reset      (reset),
    .i_rename     (rename),
    .i_tag        (tag),
    .i_rd         (rd),
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .o_rn         (rn),
    .o_rs1_ren    (rs1_ren),
    .o_rs2_ren    (rs2_ren),
    .i_src        (src),
    .o_src_value  (src_value),
    .o_src_ready  (src_ready),
    .i_cdb_write  (cdb_write),
    .i_cdb_arn    (cdb_arn),
    .i_cdb_rrn    (cdb_rrn),
    .i_cdb_result (cdb_result),
    .i_delete_tag (delete_tag),
    .i_clear_tag  (clear_tag),
    .o_capacity   (capacity)
  );

  always #4 clock = ~clock;

  // -------------------------------------------------------------------------
  // Stimulus helpers
  // -------------------------------------------------------------------------
  task automatic drive_idle();
    for (int s = 0; s < rename_width; s++) begin
      rename[s] = 1'b0;
      tag[s]    = 1'b0;
      rd[s]     = '0;
      rs1[s]    = '0;
      rs2[s]    = '0;
    end
    for (int r = 0; r < read_ports; r++) begin
      src[r] = '0;
    end
    for (int p = 0; p < cdb_ports; p++) begin
      cdb_write[p]  = 1'b0;
      cdb_arn[p]    = '0;
      cdb_rrn[p]    = '0;
      cdb_result[p] = '0;
    end
    delete_tag = 1'b0;
    clear_tag  = 1'b0;
  endtask

  task automatic load_tests();
    int               fd;
    string            line;
    string            op_text;
    logic [31:0]      a, b, c, d, e, cap;
    logic [5:0][31:0] fields;
    fd = $fopen("testbench/rename_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file testbench/rename_tests.txt");
      error_count++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // Comments and blank lines
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      if ($sscanf(line, "%s %h %h %h %h %h %h", op_text, a, b, c, d, e, cap) != 7) begin
        $display("Test line %0d could not be parsed", op_q.size() + 1);
        error_count++;
        continue;
      end
      fields = {cap, e, d, c, b, a};
      op_q.push_back(op_text);
      arg_q.push_back(fields);
    end
    $fclose(fd);
    line_count = op_q.size();
  endtask

  task automatic apply_line(input int idx);
    logic [5:0][31:0] f;
    int               port;
    f = arg_q[idx];
    port = int'(f[0][1:0]);
    drive_idle();
    case (op_q[idx])
      "RD": src[port] = reg_num_t'(f[1]);
      "REN": begin
        for (int s = 0; s < rename_width; s++) begin
          rename[s] = f[0][s];
          tag[s]    = f[1][0];
        end
        // Source under test on rs1 of slot 0 and rs2 of slot 1, x0 elsewhere
        rs1[0] = arch_num_t'(f[4]);
        rs2[0] = '0;
        rs1[1] = '0;
        rs2[1] = arch_num_t'(f[4]);
        rd[0] = arch_num_t'(f[2]);
        rd[1] = arch_num_t'(f[3]);
      end
      "WR": begin
        cdb_write[port & 1]  = 1'b1;
        cdb_arn[port & 1]    = reg_num_t'(f[1]);
        cdb_rrn[port & 1]    = reg_num_t'(f[2]);
        cdb_result[port & 1] = reg_value_t'(f[3]);
      end
      "DEL": delete_tag = 1'b1;
      "CLR": clear_tag = 1'b1;
      "RPL": begin
      end
      default: begin
        $display("Unknown operation %s on test line %0d", op_q[idx], idx + 1);
        error_count++;
      end
    endcase
  endtask

  // -------------------------------------------------------------------------
  // Checks, taken at the falling edge
  // -------------------------------------------------------------------------
  task automatic check_line(input int idx);
    logic [5:0][31:0] f;
    int               port;
    f = arg_q[idx];
    port = int'(f[0][1:0]);
    case (op_q[idx])
      "RD": begin
        check_ready($sformatf("o_src_ready[%0d]", port), f[2][0], src_ready[port]);
        check_value($sformatf("o_src_value[%0d]", port), reg_value_t'(f[3]),
                    src_value[port]);
      end
      "RPL": begin
        check_num("o_rn[0]", reg_num_t'(f[0]), rn[0]);
        check_num("o_rn[1]", reg_num_t'(f[1]), rn[1]);
        // x0 is never renamed and translates to itself
        check_num("o_rs1_ren[0]", reg_num_t'(f[2]), rs1_ren[0]);
        check_num("o_rs2_ren[0]", '0, rs2_ren[0]);
        check_num("o_rs1_ren[1]", '0, rs1_ren[1]);
        check_num("o_rs2_ren[1]", reg_num_t'(f[2]), rs2_ren[1]);
      end
      default: begin
      end
    endcase
    check_capacity("o_capacity", capacity_t'(f[5]), capacity);
  endtask

  // -------------------------------------------------------------------------
  // Main sequence
  // -------------------------------------------------------------------------
  initial begin
    clock = 1'b0;
    reset = 1'b1;
    drive_idle();
    load_tests();
    tests_loaded = 1'b1;
    if (line_count == 0) begin
      $display("No test lines were read");
      error_count++;
    end
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int i = 0; i < line_count; i++) begin
      @(posedge clock);
      #1;
      apply_line(i);
      @(negedge clock);
      check_line(i);
    end
    $display("Checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog sized from the test length
  initial begin
    wait (tests_loaded);
    #(8.0 * real'(line_count + 20));
    $display("Watchdog expired before the test lines were done");
    $display("Errors found");
    $finish;
  end

endmodule

// ==== testbench/rename_tests.txt ====
# op a b c d e cap, numbers in hex, cap is the capacity expected on that line
# RD port src ready value | REN mask tag rd0 rd1 rs | RPL rn0 rn1 rs | WR port arn rrn value
RD   0  0   1   0         0  3
RD   1  5   0   0         0  3
REN  3  0   5   6         0  3
RPL  3f 3e  0   0         0  3
REN  1  0   7   0         5  3
RPL  3d 0   3f  0         0  3
RD   2  3f  0   0         0  3
WR   0  0   3f  1234abcd  0  3
RD   3  3f  1   1234abcd  0  3
REN  3  0   a   b         0  3
REN  3  0   a   b         0  3
REN  3  0   a   b         0  3
REN  3  0   a   b         0  3
REN  3  0   a   b         0  3
REN  3  0   a   b         0  3
REN  3  0   a   b         0  3
REN  3  0   a   b         0  3
REN  3  0   a   b         0  3
REN  3  0   a   b         0  3
REN  3  0   a   b         0  3
REN  3  0   a   b         0  3
REN  3  0   a   b         0  3
REN  1  0   a   0         0  3
REN  1  0   a   0         0  2
WR   1  5   3f  1234abcd  0  1
RD   0  5   1   1234abcd  0  2
REN  0  0   0   0         5  2
RPL  0  0   5   0         0  2
REN  1  0   7   0         0  2
RPL  3f 0   0   0         0  1
WR   1  7   3d  55        0  1
RD   1  7   0   55        0  1
REN  0  0   0   0         7  1
RPL  0  0   3f  0         0  1
WR   0  6   3e  66        0  1
WR   1  b   23  77        0  2
REN  3  1   5   6         0  3
RPL  23 3e  0   0         0  1
REN  0  0   0   0         5  1
RPL  0  0   23  0         0  1
DEL  0  0   0   0         0  1
REN  0  0   0   0         5  3
RPL  0  0   5   0         0  3
RD   0  5   1   1234abcd  0  3
REN  1  1   5   0         0  3
CLR  0  0   0   0         0  2
DEL  0  0   0   0         0  2
REN  0  0   0   0         5  2
RPL  0  0   23  0         0  2

// ==== verilog/free_reg_stack.sv ====
// Free rename register stack
`timescale 1ns/1ps

module free_reg_stack
  import rename_arch_pkg::*;
(
  input  logic       i_clock,
  input  logic       i_reset,
  input  capacity_t  i_pop_count,
  output reg_num_t   o_pop_num [rename_width],
  input  logic       i_push [cdb_ports],
  input  reg_num_t   i_push_num [cdb_ports],
  input  logic       i_restore,
  input  ren_count_t i_restore_count,
  output capacity_t  o_capacity
);

  reg_num_t   stack [ren_reg_count];
  ren_count_t level;
  ren_count_t top_0;
  ren_count_t top_1;
  ren_count_t base;

  // -------------------------------------------------------------------------
  // Pop side
  // -------------------------------------------------------------------------
  // Top of stack sits just below level
  assign top_0 = level - ren_count_t'(1);
  assign top_1 = level - ren_count_t'(2);

  assign o_pop_num[0] = stack[ren_index_t'(top_0)];
  assign o_pop_num[1] = stack[ren_index_t'(top_1)];

  assign o_capacity = (level > ren_count_t'(max_capacity)) ?
                      capacity_t'(max_capacity) : capacity_t'(level);

  // Level after pops and restore, pushes land from here up
  always_comb begin
    base = level - ren_count_t'(i_pop_count);
    if (i_restore) begin
      // Speculative numbers are still in place above the level
      base = base + i_restore_count;
    end
  end

  // -------------------------------------------------------------------------
  // Stack update
  // -------------------------------------------------------------------------
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int i = 0; i < ren_reg_count; i++) begin
        stack[i] <= reg_num_t'(arch_reg_count + i);
      end
      level <= ren_count_t'(ren_reg_count);
    end else begin
      if (i_push[0]) begin
        stack[ren_index_t'(base)] <= i_push_num[0];
      end
      if (i_push[1]) begin
        stack[ren_index_t'(base + ren_count_t'(i_push[0]))] <= i_push_num[1];
      end
      level <= base + ren_count_t'(i_push[0]) + ren_count_t'(i_push[1]);
    end
  end

  // Caller must not rename past the capacity it was shown
  assert property (@(posedge i_clock) disable iff (i_reset)
    ren_count_t'(i_pop_count) <= level);

  // Frees and restores never return more numbers than exist
  assert property (@(posedge i_clock) disable iff (i_reset)
    level <= ren_count_t'(ren_reg_count));

endmodule

// ==== verilog/register_file.sv ====
// Rename map and value table
`timescale 1ns/1ps

module register_file
  import rename_arch_pkg::*;
  import rename_bus_pkg::*;
(
  input  logic            i_clock,
  input  logic            i_reset,
  rename_query_if.regfile query,
  operand_read_if.regfile operand,
  cdb_if.regfile          cdb,
  input  logic            i_delete_tag,
  input  logic            i_clear_tag,
  output capacity_t       o_pop_count,
  input  reg_num_t        i_pop_num [rename_width],
  output logic            o_push [cdb_ports],
  output reg_num_t        o_push_num [cdb_ports],
  output ren_count_t      o_restore_count
);

  reg_entry_t regs [table_size];
  reg_num_t   dest_num [rename_width];
  reg_num_t   rd_num [rename_width];

  // Mapped rename register if any, otherwise the register itself
  function automatic reg_num_t translate(input arch_num_t arn);
    reg_num_t num;
    num = reg_num_t'(arn);
    if (regs[num].rrn != '0) begin
      return regs[num].rrn;
    end
    return num;
  endfunction

  // -------------------------------------------------------------------------
  // Combinational side
  // -------------------------------------------------------------------------
  assign o_pop_count = capacity_t'(query.rename[0]) + capacity_t'(query.rename[1]);

  // Slot 1 takes the top number when slot 0 is idle
  always_comb begin
    dest_num[0] = i_pop_num[0];
    dest_num[1] = query.rename[0] ? i_pop_num[1] : i_pop_num[0];
    for (int s = 0; s < rename_width; s++) begin
      rd_num[s] = reg_num_t'(query.req[s].rd);
    end
  end

  always_comb begin
    for (int i = 0; i < read_ports; i++) begin
      operand.value[i] = regs[operand.src[i]].value;
      operand.ready[i] = regs[operand.src[i]].valid;
    end
  end

  // Commit of the live mapping frees its rename register
  always_comb begin
    for (int p = 0; p < cdb_ports; p++) begin
      o_push[p] = cdb.packet[p].write && (cdb.packet[p].arn != '0) &&
                  (cdb.packet[p].rrn == regs[cdb.packet[p].arn].rrn);
      o_push_num[p] = cdb.packet[p].rrn;
    end
  end

  // Tagged rename entries go back to the stack on delete
  always_comb begin
    o_restore_count = '0;
    for (int i = arch_reg_count; i < table_size; i++) begin
      o_restore_count = o_restore_count + ren_count_t'(regs[i].tag);
    end
  end

  // -------------------------------------------------------------------------
  // Table update
  // -------------------------------------------------------------------------
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int i = 0; i < table_size; i++) begin
        regs[i] <= '0;
      end
      regs[0].valid <= 1'b1;
      for (int s = 0; s < rename_width; s++) begin
        query.reply[s] <= '0;
      end
    end else begin
      // Rename, sources see the table before this cycle's renames
      for (int s = 0; s < rename_width; s++) begin
        query.reply[s].rs1 <= translate(query.req[s].rs1);
        query.reply[s].rs2 <= translate(query.req[s].rs2);
        query.reply[s].rn  <= query.rename[s] ? dest_num[s] : '0;
        if (query.rename[s]) begin
          regs[rd_num[s]].rrn <= dest_num[s];
          regs[rd_num[s]].tag <= query.tag[s];
          // Speculative renames keep the old value usable
          if (!query.tag[s]) begin
            regs[rd_num[s]].valid <= 1'b0;
          end
          regs[dest_num[s]] <= '{value: '0, rrn: '0, valid: 1'b0, tag: query.tag[s]};
        end
      end

      // Result buses
      for (int p = 0; p < cdb_ports; p++) begin
        if (cdb.packet[p].write) begin
          if (cdb.packet[p].arn == '0) begin
            regs[cdb.packet[p].rrn].value <= cdb.packet[p].result;
            regs[cdb.packet[p].rrn].valid <= 1'b1;
          end else begin
            regs[cdb.packet[p].arn].value <= cdb.packet[p].result;
            if (o_push[p]) begin
              regs[cdb.packet[p].arn].valid <= 1'b1;
              regs[cdb.packet[p].arn].tag   <= 1'b0;
              regs[cdb.packet[p].arn].rrn   <= '0;
            end
            regs[cdb.packet[p].rrn] <= '0;
          end
        end
      end

      // Misprediction drops speculative mappings
      if (i_delete_tag) begin
        for (int i = 0; i < arch_reg_count; i++) begin
          if (regs[i].tag) begin
            regs[i].tag <= 1'b0;
            regs[i].rrn <= '0;
          end
        end
        for (int i = arch_reg_count; i < table_size; i++) begin
          if (regs[i].tag) begin
            regs[i] <= '0;
          end
        end
      end

      // Resolved branch
      if (i_clear_tag) begin
        for (int i = 0; i < table_size; i++) begin
          regs[i].tag <= 1'b0;
        end
      end
    end
  end

  // Result writes must name a register of the rename bank
  for (genvar p = 0; p < cdb_ports; p++) begin : g_cdb_check
    assert property (@(posedge i_clock) disable iff (i_reset)
      cdb.packet[p].write |-> cdb.packet[p].rrn >= reg_num_t'(arch_reg_count));
  end

endmodule

// ==== verilog/rename_arch_pkg.sv ====
// Register numbering and table types

package rename_arch_pkg;

  // -------------------------------------------------------------------------
  // Sizes
  // -------------------------------------------------------------------------
  localparam int arch_reg_count = 32;
  localparam int ren_reg_count  = 32;
  localparam int table_size     = arch_reg_count + ren_reg_count;

  // Two-wide front end, four operand reads, two result buses
  localparam int rename_width = 2;
  localparam int read_ports   = 4;
  localparam int cdb_ports    = 2;

  // Renames reported per cycle saturate here
  localparam int max_capacity = 3;

  // -------------------------------------------------------------------------
  // Types
  // -------------------------------------------------------------------------
  // One number reaches both banks, 32 and up is the rename bank
  typedef logic [$clog2(table_size)-1:0]    reg_num_t;
  typedef logic [31:0]                      reg_value_t;
  typedef logic [$clog2(ren_reg_count)-1:0] ren_index_t;
  typedef logic [$clog2(ren_reg_count):0]   ren_count_t;
  typedef logic [1:0]                       capacity_t;

  // Table entry, 40 bits
  typedef struct packed {
    reg_value_t value;
    reg_num_t   rrn;
    logic       valid;
    logic       tag;
  } reg_entry_t;

endpackage

// ==== verilog/rename_bus_pkg.sv ====
// Rename and result bus packets

package rename_bus_pkg;
  import rename_arch_pkg::*;

  // Architectural register number as decoded
  typedef logic [$clog2(arch_reg_count)-1:0] arch_num_t;

  // -------------------------------------------------------------------------
  // Rename query
  // -------------------------------------------------------------------------
  typedef struct packed {
    arch_num_t rd;
    arch_num_t rs1;
    arch_num_t rs2;
  } rename_req_t;

  // Zero rn means the slot was not renamed
  typedef struct packed {
    reg_num_t rn;
    reg_num_t rs1;
    reg_num_t rs2;
  } rename_reply_t;

  // -------------------------------------------------------------------------
  // Result bus
  // -------------------------------------------------------------------------
  // Zero arn is an execution result, anything else a commit
  typedef struct packed {
    logic       write;
    reg_num_t   arn;
    reg_num_t   rrn;
    reg_value_t result;
  } cdb_packet_t;

endpackage

// ==== verilog/rename_interfaces.sv ====
// Rename stage interfaces
`timescale 1ns/1ps

// Rename requests in, registered replies out
interface rename_query_if
  import rename_arch_pkg::*;
  import rename_bus_pkg::*;
();
  rename_req_t   req    [rename_width];
  logic          rename [rename_width];
  logic          tag    [rename_width];
  rename_reply_t reply  [rename_width];

  modport source (
    output req, rename, tag,
    input  reply
  );

  modport regfile (
    input  req, rename, tag,
    output reply
  );
endinterface

// Operand values, answered in the same cycle
interface operand_read_if
  import rename_arch_pkg::*;
();
  reg_num_t   src   [read_ports];
  reg_value_t value [read_ports];
  logic       ready [read_ports];

  modport reader (
    output src,
    input  value, ready
  );

  modport regfile (
    input  src,
    output value, ready
  );
endinterface

// Execution results and commits
interface cdb_if
  import rename_arch_pkg::*;
  import rename_bus_pkg::*;
();
  cdb_packet_t packet [cdb_ports];

  modport driver  (output packet);
  modport regfile (input packet);
endinterface

// ==== verilog/rename_stage.sv ====
// Register rename stage top
`timescale 1ns/1ps

module rename_stage
  import rename_arch_pkg::*;
  import rename_bus_pkg::*;
(
  input  logic       i_clock,
  input  logic       i_reset,
  input  logic       i_rename [rename_width],
  input  logic       i_tag [rename_width],
  input  arch_num_t  i_rd [rename_width],
  input  arch_num_t  i_rs1 [rename_width],
  input  arch_num_t  i_rs2 [rename_width],
  output reg_num_t   o_rn [rename_width],
  output reg_num_t   o_rs1_ren [rename_width],
  output reg_num_t   o_rs2_ren [rename_width],
  input  reg_num_t   i_src [read_ports],
  output reg_value_t o_src_value [read_ports],
  output logic       o_src_ready [read_ports],
  input  logic       i_cdb_write [cdb_ports],
  input  reg_num_t   i_cdb_arn [cdb_ports],
  input  reg_num_t   i_cdb_rrn [cdb_ports],
  input  reg_value_t i_cdb_result [cdb_ports],
  input  logic       i_delete_tag,
  input  logic       i_clear_tag,
  output capacity_t  o_capacity
);

  rename_query_if query ();
  operand_read_if operand ();
  cdb_if          cdb ();

  // Stack side
  capacity_t  pop_count;
  reg_num_t   pop_num [rename_width];
  logic       push [cdb_ports];
  reg_num_t   push_num [cdb_ports];
  ren_count_t restore_count;

  // -------------------------------------------------------------------------
  // Ports to interfaces
  // -------------------------------------------------------------------------
  for (genvar s = 0; s < rename_width; s++) begin : g_rename_slot
    assign query.req[s]    = '{rd: i_rd[s], rs1: i_rs1[s], rs2: i_rs2[s]};
    assign query.rename[s] = i_rename[s];
    assign query.tag[s]    = i_tag[s];
    assign o_rn[s]         = query.reply[s].rn;
    assign o_rs1_ren[s]    = query.reply[s].rs1;
    assign o_rs2_ren[s]    = query.reply[s].rs2;
  end

  for (genvar r = 0; r < read_ports; r++) begin : g_read_port
    assign operand.src[r] = i_src[r];
    assign o_src_value[r] = operand.value[r];
    assign o_src_ready[r] = operand.ready[r];
  end

  for (genvar p = 0; p < cdb_ports; p++) begin : g_cdb_port
    assign cdb.packet[p] = '{write:  i_cdb_write[p],
                             arn:    i_cdb_arn[p],
                             rrn:    i_cdb_rrn[p],
                             result: i_cdb_result[p]};
  end

  // -------------------------------------------------------------------------
  // Table and free list
  // -------------------------------------------------------------------------
  register_file u_register_file (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .query           (query.regfile),
    .operand         (operand.regfile),
    .cdb             (cdb.regfile),
    .i_delete_tag    (i_delete_tag),
    .i_clear_tag     (i_clear_tag),
    .o_pop_count     (pop_count),
    .i_pop_num       (pop_num),
    .o_push          (push),
    .o_push_num      (push_num),
    .o_restore_count (restore_count)
  );

  free_reg_stack u_free_reg_stack (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_pop_count     (pop_count),
    .o_pop_num       (pop_num),
    .i_push          (push),
    .i_push_num      (push_num),
    .i_restore       (i_delete_tag),
    .i_restore_count (restore_count),
    .o_capacity      (o_capacity)
  );

endmodule
